// ==== src/huff_config.svh ====
`ifndef HUFF_CONFIG_SVH
`define HUFF_CONFIG_SVH

// Character slots in the frequency table
`define HUFF_NUM_CHARS 256

// Internal node slots, at most 255 ever allocated
`define HUFF_NUM_NODES 256

// Count and sum width
`define HUFF_COUNT_W 64

// Scan position width, covers every slot of both arrays
`define HUFF_SCAN_W 10

`endif

// ==== src/huff_types_pkg.sv ====
`include "huff_config.svh"

package huff_types_pkg;

    // Zero means absent, all ones means none found
    typedef logic [`HUFF_COUNT_W-1:0] count_t;

    // Bit 8 set marks an internal node, low byte is char or node number
    typedef logic [8:0] sym_t;

    typedef logic [7:0] char_t;

    // 0..255 characters, 256..511 internal nodes
    typedef logic [`HUFF_SCAN_W-1:0] scan_idx_t;

    localparam count_t COUNT_NONE = '1;
    localparam sym_t   SYM_NONE   = '1;

endpackage

// ==== src/huff_ctrl_pkg.sv ====
package huff_ctrl_pkg;

    typedef enum logic [1:0] {
        PH_IDLE,
        PH_SCAN,
        PH_MERGE,
        PH_DONE
    } build_phase_t;

    typedef struct packed {
        huff_types_pkg::sym_t   least1;
        huff_types_pkg::sym_t   least2;
        huff_types_pkg::count_t val1;
        huff_types_pkg::count_t val2;
        logic                   valid2; // Two live entries were seen
    } least_pair_t;

    typedef struct packed {
        huff_types_pkg::sym_t   node;
        huff_types_pkg::sym_t   left;
        huff_types_pkg::sym_t   right;
        huff_types_pkg::count_t sum;
    } node_rec_t;

endpackage

// ==== src/freq_table.sv ====
`timescale 1ns/1ns
`include "huff_config.svh"

module freq_table (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      load_en,
    input  huff_types_pkg::char_t     load_char,
    input  huff_types_pkg::count_t    load_count,
    input  huff_types_pkg::scan_idx_t rd_idx,
    output huff_types_pkg::count_t    rd_count,
    input  logic                      wr_en,
    input  huff_types_pkg::char_t     wr_node,
    input  huff_types_pkg::count_t    wr_count,
    input  logic                      wipe1_en,
    input  logic                      wipe2_en,
    input  huff_types_pkg::sym_t      wipe1_sym,
    input  huff_types_pkg::sym_t      wipe2_sym,
    input  logic                      busy
);

    localparam int NUM_SLOTS = `HUFF_NUM_CHARS + `HUFF_NUM_NODES;

    huff_types_pkg::count_t    char_cnt [`HUFF_NUM_CHARS];
    huff_types_pkg::count_t    node_cnt [`HUFF_NUM_NODES];
    huff_types_pkg::scan_idx_t node_off;

    assign node_off = rd_idx - huff_types_pkg::scan_idx_t'(`HUFF_NUM_CHARS);

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            for (int i = 0; i < `HUFF_NUM_CHARS; i++) begin
                char_cnt[i] <= '0;
            end
            for (int j = 0; j < `HUFF_NUM_NODES; j++) begin
                node_cnt[j] <= '0;
            end
        end else begin
            if (load_en) begin
                char_cnt[load_char] <= load_count;
            end
            if (wr_en) begin
                node_cnt[wr_node] <= wr_count; // New merged sum
            end
            if (wipe1_en) begin
                if (wipe1_sym[8]) begin
                    node_cnt[wipe1_sym[7:0]] <= '0;
                end else begin
                    char_cnt[wipe1_sym[7:0]] <= '0;
                end
            end
            if (wipe2_en) begin
                if (wipe2_sym[8]) begin
                    node_cnt[wipe2_sym[7:0]] <= '0;
                end else begin
                    char_cnt[wipe2_sym[7:0]] <= '0;
                end
            end
        end
    end

    // One cycle read latency
    always_ff @(posedge clk) begin
        if (rd_idx < `HUFF_NUM_CHARS) begin
            rd_count <= char_cnt[rd_idx[7:0]];
        end else if (rd_idx < NUM_SLOTS) begin
            rd_count <= node_cnt[node_off[7:0]];
        end else begin
            rd_count <= '0; // Past the last slot
        end
    end

    a_no_load_busy: assert property (@(posedge clk) disable iff (rst) !(load_en && busy))
        else $error("Table load during a running build");

endmodule

// ==== src/least_finder.sv ====
`timescale 1ns/1ns
`include "huff_config.svh"

module least_finder (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        scan_start,
    output huff_types_pkg::scan_idx_t   rd_idx,
    input  huff_types_pkg::count_t      rd_count,
    output logic                        pair_done,
    output huff_ctrl_pkg::least_pair_t  pair
);

    localparam huff_types_pkg::scan_idx_t LAST_IDX =
        huff_types_pkg::scan_idx_t'(`HUFF_NUM_CHARS + `HUFF_NUM_NODES - 1);

    logic                      active;  // Reads being issued
    logic                      rd_vld;  // rd_count holds a live read
    logic                      rd_last;
    huff_types_pkg::scan_idx_t rd_pos;  // Position of the read in flight
    huff_types_pkg::scan_idx_t pos_off;
    huff_types_pkg::sym_t      rd_sym;

    huff_types_pkg::sym_t      l1;
    huff_types_pkg::sym_t      l2;
    huff_types_pkg::count_t    v1;
    huff_types_pkg::count_t    v2;
    logic                      seen1;
    logic                      seen2;

    huff_types_pkg::sym_t      l1_n;
    huff_types_pkg::sym_t      l2_n;
    huff_types_pkg::count_t    v1_n;
    huff_types_pkg::count_t    v2_n;
    logic                      seen1_n;
    logic                      seen2_n;

    assign pos_off = rd_pos - huff_types_pkg::scan_idx_t'(`HUFF_NUM_CHARS);
    assign rd_sym  = (rd_pos < `HUFF_NUM_CHARS) ? {1'b0, rd_pos[7:0]} : {1'b1, pos_off[7:0]};

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            active  <= 1'b0;
            rd_idx  <= '0;
            rd_vld  <= 1'b0;
            rd_last <= 1'b0;
            rd_pos  <= '0;
        end else begin
            rd_vld  <= active;
            rd_last <= active && (rd_idx == LAST_IDX);
            rd_pos  <= rd_idx;
            if (scan_start) begin
                active <= 1'b1;
                rd_idx <= '0;
            end else if (active) begin
                if (rd_idx == LAST_IDX) begin
                    active <= 1'b0;
                    rd_idx <= '0;
                end else begin
                    rd_idx <= rd_idx + 1'b1;
                end
            end
        end
    end

    // Strict compares keep the earlier position on ties
    always_comb begin
        l1_n    = l1;
        l2_n    = l2;
        v1_n    = v1;
        v2_n    = v2;
        seen1_n = seen1;
        seen2_n = seen2;
        if (rd_vld && rd_count != '0) begin
            if (!seen1 || v1 > rd_count) begin
                l2_n    = l1; // Old least drops to second place
                v2_n    = v1;
                seen2_n = seen1;
                l1_n    = rd_sym;
                v1_n    = rd_count;
                seen1_n = 1'b1;
            end else if (!seen2 || v2 > rd_count) begin
                l2_n    = rd_sym;
                v2_n    = rd_count;
                seen2_n = 1'b1;
            end
        end
    end

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            l1        <= huff_types_pkg::SYM_NONE;
            l2        <= huff_types_pkg::SYM_NONE;
            v1        <= huff_types_pkg::COUNT_NONE;
            v2        <= huff_types_pkg::COUNT_NONE;
            seen1     <= 1'b0;
            seen2     <= 1'b0;
            pair_done <= 1'b0;
        end else begin
            pair_done <= rd_vld && rd_last;
            if (scan_start) begin
                l1    <= huff_types_pkg::SYM_NONE;
                l2    <= huff_types_pkg::SYM_NONE;
                v1    <= huff_types_pkg::COUNT_NONE;
                v2    <= huff_types_pkg::COUNT_NONE;
                seen1 <= 1'b0;
                seen2 <= 1'b0;
            end else begin
                l1    <= l1_n;
                l2    <= l2_n;
                v1    <= v1_n;
                v2    <= v2_n;
                seen1 <= seen1_n;
                seen2 <= seen2_n;
            end
        end
    end

    // Result includes the final read
    always_ff @(posedge clk) begin
        if (rd_vld && rd_last) begin
            pair.least1 <= l1_n;
            pair.least2 <= l2_n;
            pair.val1   <= v1_n;
            pair.val2   <= v2_n;
            pair.valid2 <= seen2_n;
        end
    end

    a_no_restart: assert property (@(posedge clk) disable iff (rst)
        scan_start |-> !(active || rd_vld))
        else $error("scan_start arrived during a running scan");

endmodule

// ==== src/tree_builder.sv ====
`timescale 1ns/1ns

module tree_builder (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        start,
    input  logic                        pair_done,
    input  huff_ctrl_pkg::least_pair_t  pair,
    output logic                        scan_start,
    output logic                        busy,
    output logic                        wr_en,
    output huff_types_pkg::char_t       wr_node,
    output huff_types_pkg::count_t      wr_count,
    output logic                        wipe1_en,
    output logic                        wipe2_en,
    output huff_types_pkg::sym_t        wipe1_sym,
    output huff_types_pkg::sym_t        wipe2_sym,
    output logic                        node_valid,
    output huff_ctrl_pkg::node_rec_t    node,
    output logic                        tree_done,
    output huff_types_pkg::sym_t        root
);

    huff_ctrl_pkg::build_phase_t phase;
    huff_types_pkg::char_t       node_cnt; // Next free node slot
    huff_ctrl_pkg::node_rec_t    rec;

    always_comb begin
        rec.node  = {1'b1, node_cnt};
        rec.left  = pair.least1;
        rec.right = pair.least2;
        rec.sum   = pair.val1 + pair.val2;
    end

    assign busy = (phase == huff_ctrl_pkg::PH_SCAN) || (phase == huff_ctrl_pkg::PH_MERGE);

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            phase      <= huff_ctrl_pkg::PH_IDLE;
            node_cnt   <= '0;
            scan_start <= 1'b0;
            wr_en      <= 1'b0;
            wipe1_en   <= 1'b0;
            wipe2_en   <= 1'b0;
            node_valid <= 1'b0;
            tree_done  <= 1'b0;
        end else begin
            scan_start <= 1'b0;
            wr_en      <= 1'b0;
            wipe1_en   <= 1'b0;
            wipe2_en   <= 1'b0;
            node_valid <= 1'b0;
            tree_done  <= 1'b0;
            case (phase)
                huff_ctrl_pkg::PH_IDLE, huff_ctrl_pkg::PH_DONE: begin
                    if (start) begin
                        phase      <= huff_ctrl_pkg::PH_SCAN;
                        scan_start <= 1'b1;
                        node_cnt   <= '0;
                    end
                end
                huff_ctrl_pkg::PH_SCAN: begin
                    if (pair_done && pair.valid2) begin
                        phase      <= huff_ctrl_pkg::PH_MERGE;
                        wr_en      <= 1'b1;
                        wipe1_en   <= 1'b1;
                        wipe2_en   <= 1'b1;
                        node_valid <= 1'b1;
                    end else if (pair_done) begin
                        phase     <= huff_ctrl_pkg::PH_DONE;
                        tree_done <= 1'b1;
                        wipe1_en  <= 1'b1; // Root leaves the table for the next build
                    end
                end
                huff_ctrl_pkg::PH_MERGE: begin
                    phase      <= huff_ctrl_pkg::PH_SCAN;
                    scan_start <= 1'b1;
                    node_cnt   <= node_cnt + 1'b1;
                end
                default: phase <= huff_ctrl_pkg::PH_IDLE;
            endcase
        end
    end

    // Root is least1, all ones when nothing was live
    always_ff @(posedge clk) begin
        if (pair_done) begin
            wr_node   <= node_cnt;
            wr_count  <= rec.sum;
            wipe1_sym <= pair.least1;
            wipe2_sym <= pair.least2;
            node      <= rec;
            root      <= pair.least1;
        end
    end

    a_node_range: assert property (@(posedge clk) disable iff (rst) wr_en |-> wr_node <= 8'd254)
        else $error("Node slot beyond 254 allocated");

    a_pair_in_scan: assert property (@(posedge clk) disable iff (rst)
        pair_done |-> phase == huff_ctrl_pkg::PH_SCAN)
        else $error("Scan result outside the scan phase");

endmodule

// ==== src/huff_tree_top.sv ====
`timescale 1ns/1ns

module huff_tree_top (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      load_en,
    input  huff_types_pkg::char_t     load_char,
    input  huff_types_pkg::count_t    load_count,
    input  logic                      start,
    output logic                      node_valid,
    output huff_ctrl_pkg::node_rec_t  node,
    output logic                      tree_done,
    output huff_types_pkg::sym_t      root
);

    huff_types_pkg::scan_idx_t  rd_idx;
    huff_types_pkg::count_t     rd_count;
    logic                       scan_start;
    logic                       pair_done;
    huff_ctrl_pkg::least_pair_t pair;
    logic                       busy;
    logic                       wr_en;
    huff_types_pkg::char_t      wr_node;
    huff_types_pkg::count_t     wr_count;
    logic                       wipe1_en;
    logic                       wipe2_en;
    huff_types_pkg::sym_t       wipe1_sym;
    huff_types_pkg::sym_t       wipe2_sym;

    freq_table table0 (
        .clk        (clk),
        .rst        (rst),
        .load_en    (load_en),
        .load_char  (load_char),
        .load_count (load_count),
        .rd_idx     (rd_idx),
        .rd_count   (rd_count),
        .wr_en      (wr_en),
        .wr_node    (wr_node),
        .wr_count   (wr_count),
        .wipe1_en   (wipe1_en),
        .wipe2_en   (wipe2_en),
        .wipe1_sym  (wipe1_sym),
        .wipe2_sym  (wipe2_sym),
        .busy       (busy)
    );

    least_finder finder0 (
        .clk        (clk),
        .rst        (rst),
        .scan_start (scan_start),
        .rd_idx     (rd_idx),
        .rd_count   (rd_count),
        .pair_done  (pair_done),
        .pair       (pair)
    );

    tree_builder builder0 (
        .clk        (clk),
        .rst        (rst),
        .start      (start),
        .pair_done  (pair_done),
        .pair       (pair),
        .scan_start (scan_start),
        .busy       (busy),
        .wr_en      (wr_en),
        .wr_node    (wr_node),
        .wr_count   (wr_count),
        .wipe1_en   (wipe1_en),
        .wipe2_en   (wipe2_en),
        .wipe1_sym  (wipe1_sym),
        .wipe2_sym  (wipe2_sym),
        .node_valid (node_valid),
        .node       (node),
        .tree_done  (tree_done),
        .root       (root)
    );

endmodule

// ==== testbench/tb_clock.sv ====
`timescale 1ns/1ns

module tb_clock #(
    parameter int HALF_NS    = 20,
    parameter int RST_CYCLES = 16
) (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        rst = 1'b1;
        repeat (RST_CYCLES) @(posedge clk);
        rst <= 1'b0;
    end

    always #HALF_NS clk = ~clk; // 40 ns period

endmodule

// ==== testbench/huff_tree_tb.sv ====
`timescale 1ns/1ns
`include "huff_config.svh"

module huff_tree_tb;

    localparam int WAIT_LIMIT  = 2000; // Cycles allowed for one node or the completion
    localparam int RESET_LIMIT = 100;

    logic                     clk;
    logic                     rst;
    logic                     load_en;
    huff_types_pkg::char_t    load_char;
    huff_types_pkg::count_t   load_count;
    logic                     start;
    logic                     node_valid;
    huff_ctrl_pkg::node_rec_t node;
    logic                     tree_done;
    huff_types_pkg::sym_t     root;

    huff_types_pkg::count_t ref_char [`HUFF_NUM_CHARS]; // Live entries of the model
    huff_types_pkg::count_t ref_node [`HUFF_NUM_NODES];
    logic [31:0]            lcg_state;
    int                     errors;
    int                     tests_run;
    int                     tests_failed;
    logic                   timed_out;

    tb_clock clock0 (.clk(clk), .rst(rst));

    huff_tree_top dut0 (
        .clk        (clk),
        .rst        (rst),
        .load_en    (load_en),
        .load_char  (load_char),
        .load_count (load_count),
        .start      (start),
        .node_valid (node_valid),
        .node       (node),
        .tree_done  (tree_done),
        .root       (root)
    );

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic huff_types_pkg::count_t model_count(input huff_types_pkg::sym_t s);
        return s[8] ? ref_node[s[7:0]] : ref_char[s[7:0]];
    endfunction

    task automatic report_value(input string test, input string what,
                                input logic [63:0] expected, input logic [63:0] actual);
        errors++;
        $display("Error %s %s expected %0h actual %0h", test, what, expected, actual);
    endtask

    task automatic report_fault(input string test, input string what);
        errors++;
        $display("Error %s: %s", test, what);
    endtask

    // Index order, characters before nodes, ties stay with the earlier entry
    task automatic find_least(output huff_types_pkg::sym_t s1, output huff_types_pkg::sym_t s2,
                              output huff_types_pkg::count_t c1,
                              output huff_types_pkg::count_t c2, output int live);
        huff_types_pkg::sym_t   s;
        huff_types_pkg::count_t c;
        s1   = '1;
        s2   = '1;
        c1   = '1;
        c2   = '1;
        live = 0;
        for (int i = 0; i < `HUFF_NUM_CHARS + `HUFF_NUM_NODES; i++) begin
            s = (i < `HUFF_NUM_CHARS) ? {1'b0, i[7:0]} : {1'b1, i[7:0]};
            c = model_count(s);
            if (c != '0) begin
                live++;
                if (live == 1 || c < c1) begin
                    s2 = s1;
                    c2 = c1;
                    s1 = s;
                    c1 = c;
                end else if (live == 2 || c < c2) begin
                    s2 = s;
                    c2 = c;
                end
            end
        end
    endtask

    task automatic wipe_sym(input huff_types_pkg::sym_t s);
        if (s[8]) begin
            ref_node[s[7:0]] = '0;
        end else begin
            ref_char[s[7:0]] = '0;
        end
    endtask

    task automatic clear_model();
        for (int i = 0; i < `HUFF_NUM_CHARS; i++) begin
            ref_char[i] = '0;
        end
        for (int j = 0; j < `HUFF_NUM_NODES; j++) begin
            ref_node[j] = '0;
        end
    endtask

    task automatic fill_random(input int n);
        int                    placed;
        int                    tries;
        huff_types_pkg::char_t c;
        clear_model();
        placed = 0;
        tries  = 0;
        while (placed < n && tries < 10000) begin
            c = huff_types_pkg::char_t'(next_rand() >> 16);
            tries++;
            if (ref_char[c] == '0) begin
                ref_char[c] = 64'((next_rand() >> 20) % 32) + 64'd1; // Small range gives ties
                placed++;
            end
        end
    endtask

    // Every slot is written, zeros included
    task automatic load_table();
        for (int i = 0; i < `HUFF_NUM_CHARS; i++) begin
            @(posedge clk);
            load_en    <= 1'b1;
            load_char  <= huff_types_pkg::char_t'(i);
            load_count <= ref_char[i];
        end
        @(posedge clk);
        load_en <= 1'b0;
    endtask

    task automatic pulse_start();
        @(posedge clk);
        start <= 1'b1;
        @(posedge clk);
        start <= 1'b0;
    endtask

    task automatic wait_reset();
        int n;
        n = 0;
        @(posedge clk);
        while (rst && n < RESET_LIMIT) begin
            @(posedge clk);
            n++;
        end
        if (rst) begin
            timed_out = 1'b1;
            $display("Timeout: reset was never released");
        end
    endtask

    task automatic wait_event(output logic seen_node, output logic seen_done);
        int n;
        seen_node = 1'b0;
        seen_done = 1'b0;
        n = 0;
        while (!seen_node && !seen_done && n < WAIT_LIMIT) begin
            @(posedge clk);
            seen_node = node_valid;
            seen_done = tree_done;
            n++;
        end
        if (!seen_node && !seen_done) begin
            timed_out = 1'b1;
            $display("Timeout: no node record and no completion within %0d cycles", WAIT_LIMIT);
        end
    endtask

    task automatic run_build(input string name, input logic busy_start);
        huff_types_pkg::sym_t   s1;
        huff_types_pkg::sym_t   s2;
        huff_types_pkg::count_t c1;
        huff_types_pkg::count_t c2;
        huff_types_pkg::count_t total;
        huff_types_pkg::sym_t   last_sym;
        huff_types_pkg::count_t last_sum;
        int                     live;
        int                     chars;
        int                     nodes;
        int                     err0;
        logic                   seen_node;
        logic                   seen_done;
        if (timed_out) return;
        err0      = errors;
        chars     = 0;
        nodes     = 0;
        total     = '0;
        last_sym  = '1;
        last_sum  = '0;
        seen_done = 1'b0;
        for (int i = 0; i < `HUFF_NUM_CHARS; i++) begin
            if (ref_char[i] != '0) begin
                chars++;
                total += ref_char[i];
            end
        end
        load_table();
        pulse_start();
        while (!seen_done && !timed_out) begin
            wait_event(seen_node, seen_done);
            if (seen_node) begin
                find_least(s1, s2, c1, c2, live);
                assert (live >= 2) else report_fault(name, "node record with one live entry");
                assert (model_count(node.left) != '0 && model_count(node.right) != '0)
                    else report_fault(name, "absent or consumed symbol used as a child");
                assert (node.node == {1'b1, 8'(nodes)})
                    else report_value(name, "node", {1'b1, 8'(nodes)}, node.node);
                assert (node.left == s1) else report_value(name, "left", s1, node.left);
                assert (node.right == s2) else report_value(name, "right", s2, node.right);
                assert (node.sum == c1 + c2) else report_value(name, "sum", c1 + c2, node.sum);
                wipe_sym(s1);
                wipe_sym(s2);
                ref_node[nodes] = c1 + c2;
                last_sym = node.node;
                last_sum = node.sum;
                nodes++;
                if (busy_start && nodes == 1) begin
                    pulse_start(); // Lands in the second scan, a restart would renumber nodes
                end
            end
        end
        if (seen_done) begin
            find_least(s1, s2, c1, c2, live);
            assert (live <= 1) else report_fault(name, "completion with two live entries left");
            assert (root == s1) else report_value(name, "root", s1, root);
            assert (nodes == ((chars > 0) ? chars - 1 : 0))
                else report_value(name, "node count", (chars > 0) ? chars - 1 : 0, nodes);
            if (chars >= 2) begin
                assert (root == last_sym) else report_value(name, "root node", last_sym, root);
                assert (last_sum == total) else report_value(name, "root sum", total, last_sum);
            end
            @(posedge clk);
            assert (!tree_done && !node_valid)
                else report_fault(name, "completion was not a single pulse");
        end
        tests_run++;
        if (errors != err0 || timed_out) begin
            tests_failed++;
        end
        $display("Test %s: %s, %0d chars, %0d nodes", name,
                 (errors == err0 && !timed_out) ? "ok" : "error", chars, nodes);
    endtask

    initial begin
        load_en      = 1'b0;
        load_char    = '0;
        load_count   = '0;
        start        = 1'b0;
        lcg_state    = 32'h2ec8a412;
        errors       = 0;
        tests_run    = 0;
        tests_failed = 0;
        timed_out    = 1'b0;
        wait_reset();

        clear_model();
        ref_char[8'h61] = 64'd5;
        ref_char[8'h62] = 64'd5;
        ref_char[8'h63] = 64'd3;
        ref_char[8'h64] = 64'd3;
        ref_char[8'h65] = 64'd7;
        ref_char[8'h00] = 64'd1;
        ref_char[8'hff] = 64'd1;
        ref_char[8'h20] = 64'h1_0000_0000; // Sums beyond 32 bits
        run_build("ties_fixed", 1'b0);

        clear_model();
        ref_char[8'h41] = 64'd9;
        run_build("single_char", 1'b0);

        clear_model();
        run_build("empty_table", 1'b0);

        clear_model();
        for (int k = 0; k < 6; k++) begin
            ref_char[8'h30 + k * 7] = 64'd4; // Equal counts everywhere
        end
        run_build("rebuild_busy_start", 1'b1);

        for (int t = 0; t < 6 && !timed_out; t++) begin
            fill_random(2 + int'((next_rand() >> 12) % 39));
            run_build($sformatf("random_%0d", t), 1'b0);
        end

        $display("Tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0 && !timed_out) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

// ==== sim.f ====
+incdir+src
src/huff_types_pkg.sv
src/huff_ctrl_pkg.sv
src/freq_table.sv
src/least_finder.sv
src/tree_builder.sv
src/huff_tree_top.sv
testbench/tb_clock.sv
testbench/huff_tree_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= huff_tree_tb
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal --timescale 1ns/1ns

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o $(TOP)
	$(BUILD_DIR)/$(TOP) > $(LOG) 2>&1 || (cat $(LOG); exit 1)
	@cat $(LOG)
	@if grep -q "Testbench failed" $(LOG); then exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
